// ==== Bender.yml ====
package:
  name: dsb_router

sources:
  - common/dsb_pkg.sv
  - common/flit_chan_if.sv
  - hw/flit_fifo.sv
  - hw/rr_arbiter.sv
  - hw/router/input_port.sv
  - hw/router/mm_alloc.sv
  - hw/router/output_alloc.sv
  - hw/dsb_router.sv
  - target: test
    files:
      - tb/tb_dsb_router.sv

// ==== build.f ====
common/dsb_pkg.sv
common/flit_chan_if.sv
hw/flit_fifo.sv
hw/rr_arbiter.sv
hw/router/input_port.sv
hw/router/mm_alloc.sv
hw/router/output_alloc.sv
hw/dsb_router.sv
tb/tb_dsb_router.sv

// ==== common/dsb_pkg.sv ====
package dsb_pkg;

    // ------------------------------------------------------------
    // Router geometry and flit layout
    // ------------------------------------------------------------

    // Ports S, W, N, E, P
    localparam int NUM_PORTS = 5;

    // Mesh coordinate width, one axis
    localparam int COORD_W = 3;

    localparam int PAYLOAD_W = 10;

    // Two coordinates plus payload
    localparam int FLIT_W = 2 * COORD_W + PAYLOAD_W;

    // ------------------------------------------------------------
    // Types
    // ------------------------------------------------------------

    // Output direction, also the type tag of a middle memory
    typedef enum logic [2:0] {
        PORT_S = 3'd0,
        PORT_W = 3'd1,
        PORT_N = 3'd2,
        PORT_E = 3'd3,
        PORT_P = 3'd4
    } port_e;

    // Single-flit packet, destination in the upper bits
    typedef struct packed {
        logic [COORD_W-1:0]   dest_x;
        logic [COORD_W-1:0]   dest_y;
        logic [PAYLOAD_W-1:0] payload;
    } flit_t;

endpackage

// ==== common/flit_chan_if.sv ====
`timescale 1ns/1ps

// Flit transfer between router stages
// A flit moves on a rising edge where valid and take are both high
interface flit_chan_if;

    logic           valid;
    dsb_pkg::flit_t flit;
    // Output the flit is heading for
    dsb_pkg::port_e dest;
    logic           take;

    modport src (
        output valid,
        output flit,
        output dest,
        input  take
    );

    modport dst (
        input  valid,
        input  flit,
        input  dest,
        output take
    );

endinterface

// ==== hw/dsb_router.sv ====
`timescale 1ns/1ps

// Five-port distributed shared-buffer router
module dsb_router #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [dsb_pkg::COORD_W-1:0]   lx_i,
    input  logic [dsb_pkg::COORD_W-1:0]   ly_i,
    input  logic [dsb_pkg::NUM_PORTS-1:0] in_req_i,
    input  dsb_pkg::flit_t                in_data_i [dsb_pkg::NUM_PORTS],
    output logic [dsb_pkg::NUM_PORTS-1:0] in_ack_o,
    output logic [dsb_pkg::NUM_PORTS-1:0] out_req_o,
    output dsb_pkg::flit_t                out_data_o [dsb_pkg::NUM_PORTS],
    input  logic [dsb_pkg::NUM_PORTS-1:0] out_ack_i
);

    // Input ports to memories, memories to outputs
    flit_chan_if in_ch [dsb_pkg::NUM_PORTS] ();
    flit_chan_if mm_ch [dsb_pkg::NUM_PORTS] ();

    for (genvar i = 0; i < dsb_pkg::NUM_PORTS; i++) begin : g_port
        input_port #(.FIFO_DEPTH(FIFO_DEPTH)) u_in (
            .clk    (clk),
            .rst    (rst),
            .req_i  (in_req_i[i]),
            .data_i (in_data_i[i]),
            .lx_i   (lx_i),
            .ly_i   (ly_i),
            .ack_o  (in_ack_o[i]),
            .ch     (in_ch[i])
        );
    end

    mm_alloc #(.FIFO_DEPTH(FIFO_DEPTH)) u_mm (
        .clk   (clk),
        .rst   (rst),
        .in_ch (in_ch),
        .mm_ch (mm_ch)
    );

    output_alloc u_out (
        .mm_ch  (mm_ch),
        .clk    (clk),
        .rst    (rst),
        .ack_i  (out_ack_i),
        .req_o  (out_req_o),
        .data_o (out_data_o)
    );

endmodule

// ==== hw/flit_fifo.sv ====
`timescale 1ns/1ps

// Circular buffer with the head word visible on data_o
module flit_fifo #(
    parameter int DEPTH = 4
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           push_i,
    input  logic           pop_i,
    input  dsb_pkg::flit_t data_i,
    output dsb_pkg::flit_t data_o,
    output logic           empty_o,
    output logic           full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [dsb_pkg::FLIT_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [CNT_W-1:0]           count;

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));
    assign data_o  = dsb_pkg::flit_t'(mem[rd_ptr]);

    // Flit storage
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push_i) - CNT_W'(pop_i);
        end
    end

    // Callers must respect full and empty
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        !(push_i && full_o) && !(pop_i && empty_o));

endmodule

// ==== hw/router/input_port.sv ====
`timescale 1ns/1ps

// One router input: buffer, acknowledge and XY route of the head flit
module input_port #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req_i,
    input  dsb_pkg::flit_t              data_i,
    input  logic [dsb_pkg::COORD_W-1:0] lx_i,
    input  logic [dsb_pkg::COORD_W-1:0] ly_i,
    output logic                        ack_o,
    flit_chan_if.src                    ch
);

    logic           empty;
    logic           full;
    dsb_pkg::flit_t head;

    // Accept whenever there is room
    assign ack_o = req_i && !full;

    flit_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
        .clk     (clk),
        .rst     (rst),
        .push_i  (ack_o),
        .pop_i   (ch.take),
        .data_i  (data_i),
        .data_o  (head),
        .empty_o (empty),
        .full_o  (full)
    );

    assign ch.valid = !empty;
    assign ch.flit  = head;

    // X first, then Y, then local
    always_comb begin
        if (head.dest_x > lx_i) begin
            ch.dest = dsb_pkg::PORT_E;
        end else if (head.dest_x < lx_i) begin
            ch.dest = dsb_pkg::PORT_W;
        end else if (head.dest_y > ly_i) begin
            ch.dest = dsb_pkg::PORT_N;
        end else if (head.dest_y < ly_i) begin
            ch.dest = dsb_pkg::PORT_S;
        end else begin
            ch.dest = dsb_pkg::PORT_P;
        end
    end

endmodule

// ==== hw/router/mm_alloc.sv ====
`timescale 1ns/1ps

// First crossbar stage and the shared middle memories
module mm_alloc #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic     clk,
    input  logic     rst,
    flit_chan_if.dst in_ch [dsb_pkg::NUM_PORTS],
    flit_chan_if.src mm_ch [dsb_pkg::NUM_PORTS]
);

    localparam int N = dsb_pkg::NUM_PORTS;

    logic [N-1:0]   in_valid;
    dsb_pkg::flit_t in_flit [N];
    dsb_pkg::port_e in_dest [N];

    // Indexed [input][memory]
    logic [N-1:0]   compat    [N];
    logic [N-1:0]   arb_gnt   [N];
    logic [N-1:0]   final_gnt [N];
    // Indexed [memory][input]
    logic [N-1:0]   col_gnt   [N];

    logic [N-1:0]   mm_push;
    logic [N-1:0]   mm_empty;
    logic [N-1:0]   mm_full;
    dsb_pkg::flit_t mm_wdata [N];
    dsb_pkg::flit_t mm_rdata [N];
    dsb_pkg::port_e mm_wtype [N];
    dsb_pkg::port_e mm_type  [N];

    // ------------------------------------------------------------
    // Input side: compatibility and per-input arbitration
    // ------------------------------------------------------------
    for (genvar i = 0; i < N; i++) begin : g_in
        assign in_valid[i] = in_ch[i].valid;
        assign in_flit[i]  = in_ch[i].flit;
        assign in_dest[i]  = in_ch[i].dest;
        assign in_ch[i].take = |final_gnt[i];

        // Empty memory takes anything, otherwise only its own type
        for (genvar j = 0; j < N; j++) begin : g_compat
            assign compat[i][j] = in_valid[i] && !mm_full[j] &&
                                  (mm_empty[j] || (mm_type[j] == in_dest[i]));
        end

        rr_arbiter u_arb (
            .clk       (clk),
            .rst       (rst),
            .req_i     (compat[i]),
            .advance_i (|final_gnt[i]),
            .gnt_o     (arb_gnt[i])
        );
    end

    // Input 0 wins a contested memory, then 1, and so on
    always_comb begin
        logic [N-1:0] used;
        used = '0;
        for (int i = 0; i < N; i++) begin
            final_gnt[i] = arb_gnt[i] & ~used;
            used         = used | final_gnt[i];
        end
        for (int j = 0; j < N; j++) begin
            for (int i = 0; i < N; i++) begin
                col_gnt[j][i] = final_gnt[i][j];
            end
        end
    end

    // Crossbar into the memories
    always_comb begin
        for (int j = 0; j < N; j++) begin
            mm_wdata[j] = '0;
            mm_wtype[j] = dsb_pkg::PORT_S;
            for (int i = 0; i < N; i++) begin
                if (col_gnt[j][i]) begin
                    mm_wdata[j] = in_flit[i];
                    mm_wtype[j] = in_dest[i];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Middle memories and their type tags
    // ------------------------------------------------------------
    for (genvar j = 0; j < N; j++) begin : g_mm
        assign mm_push[j] = |col_gnt[j];

        // Tag is only meaningful while the memory holds flits
        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                mm_type[j] <= dsb_pkg::PORT_S;
            end else if (mm_push[j] && mm_empty[j]) begin
                mm_type[j] <= mm_wtype[j];
            end
        end

        flit_fifo #(.DEPTH(FIFO_DEPTH)) u_mem (
            .clk     (clk),
            .rst     (rst),
            .push_i  (mm_push[j]),
            .pop_i   (mm_ch[j].take),
            .data_i  (mm_wdata[j]),
            .data_o  (mm_rdata[j]),
            .empty_o (mm_empty[j]),
            .full_o  (mm_full[j])
        );

        assign mm_ch[j].valid = !mm_empty[j];
        assign mm_ch[j].flit  = mm_rdata[j];
        assign mm_ch[j].dest  = mm_type[j];

        a_single_writer: assert property (@(posedge clk) disable iff (rst)
            $onehot0(col_gnt[j]));
    end

endmodule

// ==== hw/router/output_alloc.sv ====
`timescale 1ns/1ps

// Second crossbar stage with one arbiter per output
module output_alloc (
    flit_chan_if.dst                      mm_ch [dsb_pkg::NUM_PORTS],
    input  logic                          clk,
    input  logic                          rst,
    input  logic [dsb_pkg::NUM_PORTS-1:0] ack_i,
    output logic [dsb_pkg::NUM_PORTS-1:0] req_o,
    output dsb_pkg::flit_t                data_o [dsb_pkg::NUM_PORTS]
);

    localparam int N = dsb_pkg::NUM_PORTS;

    logic [N-1:0]   mm_valid;
    dsb_pkg::flit_t mm_flit [N];
    dsb_pkg::port_e mm_dest [N];
    logic [N-1:0]   mm_take;

    // Indexed [output][memory]
    logic [N-1:0]   out_req [N];
    logic [N-1:0]   out_gnt [N];

    for (genvar j = 0; j < N; j++) begin : g_mm
        assign mm_valid[j] = mm_ch[j].valid;
        assign mm_flit[j]  = mm_ch[j].flit;
        assign mm_dest[j]  = mm_ch[j].dest;
        assign mm_ch[j].take = mm_take[j];
    end

    // A memory carries one type, so at most one output grants it
    always_comb begin
        mm_take = '0;
        for (int k = 0; k < N; k++) begin
            if (ack_i[k]) begin
                mm_take = mm_take | out_gnt[k];
            end
        end
    end

    for (genvar k = 0; k < N; k++) begin : g_out
        for (genvar j = 0; j < N; j++) begin : g_req
            assign out_req[k][j] = mm_valid[j] && (mm_dest[j] == dsb_pkg::port_e'(k));
        end

        rr_arbiter u_arb (
            .clk       (clk),
            .rst       (rst),
            .req_i     (out_req[k]),
            .advance_i (req_o[k] && ack_i[k]),
            .gnt_o     (out_gnt[k])
        );

        assign req_o[k] = |out_gnt[k];

        always_comb begin
            data_o[k] = '0;
            for (int j = 0; j < N; j++) begin
                if (out_gnt[k][j]) begin
                    data_o[k] = mm_flit[j];
                end
            end
        end

        // The arbiter holds its winner while the receiver stalls
        a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
            req_o[k] && !ack_i[k] |=> req_o[k] && $stable(data_o[k]));
    end

endmodule

// ==== hw/rr_arbiter.sv ====
`timescale 1ns/1ps

// Round-robin arbiter
// The pointer sits on the current winner until advance_i, then moves past it
module rr_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [dsb_pkg::NUM_PORTS-1:0] req_i,
    input  logic                          advance_i,
    output logic [dsb_pkg::NUM_PORTS-1:0] gnt_o
);

    localparam int N     = dsb_pkg::NUM_PORTS;
    localparam int PTR_W = $clog2(N);

    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] win;

    // First requester at or after the pointer
    always_comb begin
        int   idx;
        logic found;
        gnt_o = '0;
        win   = ptr;
        found = 1'b0;
        for (int off = 0; off < N; off++) begin
            idx = (int'(ptr) + off) % N;
            if (!found && req_i[idx]) begin
                gnt_o[idx] = 1'b1;
                win        = PTR_W'(idx);
                found      = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr <= '0;
        end else if (|gnt_o) begin
            if (advance_i) begin
                ptr <= (win == PTR_W'(N - 1)) ? '0 : win + 1'b1;
            end else begin
                ptr <= win;
            end
        end
    end

    a_gnt_legal: assert property (@(posedge clk) disable iff (rst)
        $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0));

endmodule

// ==== tb/tb_dsb_router.sv ====
`timescale 1ns/1ps

module tb_dsb_router;

    localparam int NP = dsb_pkg::NUM_PORTS;
    localparam int LX = 3;
    localparam int LY = 3;

    // Flits injected by each test, used to size the timeout
    localparam int N_T1 = 3;
    localparam int N_T2 = 5;
    localparam int N_T3 = 5;
    localparam int N_T4 = 32;
    localparam int N_T5 = 16;
    localparam int N_T6 = 200;
    localparam int TOTAL_FLITS = N_T1 + N_T2 + N_T3 + N_T4 + N_T5 + N_T6;
    localparam int CYCLE_LIMIT = 40 * TOTAL_FLITS + 200;

    logic                        clk;
    logic                        rst;
    logic [dsb_pkg::COORD_W-1:0] lx_i;
    logic [dsb_pkg::COORD_W-1:0] ly_i;
    logic [NP-1:0]               in_req_i;
    dsb_pkg::flit_t              in_data_i [NP];
    logic [NP-1:0]               in_ack_o;
    logic [NP-1:0]               out_req_o;
    dsb_pkg::flit_t              out_data_o [NP];
    logic [NP-1:0]               out_ack_i;

    // Pending flits per input and expected flits per output
    dsb_pkg::flit_t send_q [NP][$];
    dsb_pkg::flit_t exp_q  [NP][$];
    logic [NP-1:0]  took_in;
    logic [NP-1:0]  stall;
    logic           ack_gaps;
    int             seed = 86;
    int             cycle;

    dsb_router #(.FIFO_DEPTH(4)) dut (
        .clk        (clk),
        .rst        (rst),
        .lx_i       (lx_i),
        .ly_i       (ly_i),
        .in_req_i   (in_req_i),
        .in_data_i  (in_data_i),
        .in_ack_o   (in_ack_o),
        .out_req_o  (out_req_o),
        .out_data_o (out_data_o),
        .out_ack_i  (out_ack_i)
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    // ------------------------------------------------------------
    // Reference route and compare tasks
    // ------------------------------------------------------------
    function automatic dsb_pkg::port_e xy_route(input dsb_pkg::flit_t f);
        if (f.dest_x > LX) return dsb_pkg::PORT_E;
        if (f.dest_x < LX) return dsb_pkg::PORT_W;
        if (f.dest_y > LY) return dsb_pkg::PORT_N;
        if (f.dest_y < LY) return dsb_pkg::PORT_S;
        return dsb_pkg::PORT_P;
    endfunction

    // One destination per direction, seen from (3,3)
    function automatic dsb_pkg::flit_t flit_toward(input dsb_pkg::port_e d, input int pl);
        dsb_pkg::flit_t f;
        f.payload = pl[dsb_pkg::PAYLOAD_W-1:0];
        f.dest_x  = 3'd3;
        f.dest_y  = 3'd3;
        case (d)
            dsb_pkg::PORT_S: f.dest_y = 3'd0;
            dsb_pkg::PORT_W: f.dest_x = 3'd1;
            dsb_pkg::PORT_N: f.dest_y = 3'd7;
            dsb_pkg::PORT_E: f.dest_x = 3'd6;
            default:         f.dest_x = 3'd3;
        endcase
        return f;
    endfunction

    task automatic check_flit(input string name, input dsb_pkg::flit_t got,
                              input dsb_pkg::flit_t exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_port(input string name, input dsb_pkg::port_e got,
                              input dsb_pkg::port_e exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // ------------------------------------------------------------
    // Driver, monitor and scoreboard
    // ------------------------------------------------------------
    always @(posedge clk) begin
        #1;
        for (int p = 0; p < NP; p++) begin
            if (took_in[p]) begin
                void'(send_q[p].pop_front());
            end
            in_req_i[p]  = (send_q[p].size() > 0);
            in_data_i[p] = (send_q[p].size() > 0) ? send_q[p][0] : '0;
        end
        for (int k = 0; k < NP; k++) begin
            out_ack_i[k] = !stall[k] && (!ack_gaps || ($random(seed) % 3 != 0));
        end
    end

    task automatic take_delivered(input int k, input dsb_pkg::flit_t f);
        int hit;
        hit = -1;
        for (int e = 0; e < exp_q[k].size(); e++) begin
            if (hit < 0 && exp_q[k][e] == f) begin
                hit = e;
            end
        end
        if (hit < 0) begin
            $display("error: out_data_o[%0d] got %h, no such flit expected there", k, f);
            abort_run();
        end else begin
            exp_q[k].delete(hit);
        end
    endtask

    // Handshakes seen here complete at the next rising edge
    always @(negedge clk) begin
        for (int p = 0; p < NP; p++) begin
            took_in[p] = in_req_i[p] && in_ack_o[p];
        end
        if (!rst) begin
            for (int p = 0; p < NP; p++) begin
                if (took_in[p]) begin
                    exp_q[int'(xy_route(in_data_i[p]))].push_back(in_data_i[p]);
                end
            end
            for (int k = 0; k < NP; k++) begin
                if (out_req_o[k] && out_ack_i[k]) begin
                    take_delivered(k, out_data_o[k]);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: traffic did not drain within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    task automatic wait_drained();
        logic busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            busy = 1'b0;
            for (int p = 0; p < NP; p++) begin
                if (send_q[p].size() > 0 || exp_q[p].size() > 0) begin
                    busy = 1'b1;
                end
            end
        end
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic after_reset();
        @(negedge clk);
        for (int p = 0; p < NP; p++) begin
            check_bit($sformatf("out_req_o[%0d]", p), out_req_o[p], 1'b0);
            check_bit($sformatf("in_ack_o[%0d]", p), in_ack_o[p], 1'b0);
        end
        send_q[1].push_back(flit_toward(dsb_pkg::PORT_E, 1));
        send_q[2].push_back(flit_toward(dsb_pkg::PORT_S, 2));
        send_q[4].push_back(flit_toward(dsb_pkg::PORT_W, 3));
        do @(negedge clk); while (in_req_i == '0);
        for (int p = 0; p < NP; p++) begin
            check_bit($sformatf("in_ack_o[%0d]", p), in_ack_o[p], in_req_i[p]);
            check_bit($sformatf("out_req_o[%0d]", p), out_req_o[p], 1'b0);
        end
        wait_drained();
    endtask

    task automatic single_flit_latency();
        dsb_pkg::flit_t f;
        dsb_pkg::port_e dir;
        dsb_pkg::port_e got;
        int             n_req;
        for (int i = 0; i < N_T2; i++) begin
            dir = dsb_pkg::port_e'(NP - 1 - i);
            f   = flit_toward(dir, 16 + i);
            send_q[i].push_back(f);
            do @(negedge clk); while (!(in_req_i[i] && in_ack_o[i]));
            @(posedge clk);
            @(negedge clk);
            check_bit("out_req_o after one edge", out_req_o[int'(dir)], 1'b0);
            @(posedge clk);
            @(negedge clk);
            check_bit("out_req_o after two edges", out_req_o[int'(dir)], 1'b1);
            got   = dsb_pkg::PORT_P;
            n_req = 0;
            for (int k = 0; k < NP; k++) begin
                if (out_req_o[k]) begin
                    got   = dsb_pkg::port_e'(k);
                    n_req = n_req + 1;
                end
            end
            check_bit("single requesting output", n_req == 1, 1'b1);
            check_port("delivering output", got, dir);
            check_flit("out_data_o", out_data_o[int'(dir)], f);
            wait_drained();
        end
    endtask

    task automatic all_inputs_at_once();
        for (int i = 0; i < N_T3; i++) begin
            send_q[i].push_back(flit_toward(dsb_pkg::port_e'((i + 1) % NP), 32 + i));
        end
        wait_drained();
    endtask

    task automatic east_backpressure();
        dsb_pkg::flit_t held;
        logic           seen_req;
        logic           dropped;
        stall[int'(dsb_pkg::PORT_E)] = 1'b1;
        for (int n = 0; n < N_T4 / 2; n++) begin
            send_q[0].push_back(flit_toward(dsb_pkg::PORT_E, 64 + n));
            send_q[4].push_back(flit_toward(dsb_pkg::PORT_E, 96 + n));
        end
        seen_req = 1'b0;
        dropped  = 1'b0;
        while (!dropped) begin
            @(negedge clk);
            if (seen_req) begin
                check_bit("out_req_o[3]", out_req_o[3], 1'b1);
                check_flit("out_data_o[3]", out_data_o[3], held);
            end else if (out_req_o[3]) begin
                seen_req = 1'b1;
                held     = out_data_o[3];
            end
            for (int p = 0; p < NP; p++) begin
                if (in_req_i[p] && !in_ack_o[p]) begin
                    dropped = 1'b1;
                end
            end
        end
        stall = '0;
        wait_drained();
    endtask

    task automatic shared_output();
        for (int n = 0; n < N_T5 / 4; n++) begin
            send_q[0].push_back(flit_toward(dsb_pkg::PORT_N, 128 + n));
            send_q[1].push_back(flit_toward(dsb_pkg::PORT_N, 144 + n));
            send_q[2].push_back(flit_toward(dsb_pkg::PORT_N, 160 + n));
            send_q[4].push_back(flit_toward(dsb_pkg::PORT_N, 176 + n));
        end
        wait_drained();
    endtask

    task automatic random_traffic();
        int rnd;
        int src;
        ack_gaps = 1'b1;
        for (int n = 0; n < N_T6; n++) begin
            src = $unsigned($random(seed)) % NP;
            rnd = $random(seed);
            send_q[src].push_back(rnd[dsb_pkg::FLIT_W-1:0]);
        end
        wait_drained();
        ack_gaps = 1'b0;
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        lx_i      = 3'(LX);
        ly_i      = 3'(LY);
        in_req_i  = '0;
        in_data_i = '{default: '0};
        out_ack_i = '0;
        took_in   = '0;
        stall     = '0;
        ack_gaps  = 1'b0;
        cycle     = 0;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        after_reset();
        single_flit_latency();
        all_inputs_at_once();
        east_backpressure();
        shared_output();
        random_traffic();

        // A leftover or duplicated flit would reach an output within the idle latency
        repeat (3) @(negedge clk);
        for (int k = 0; k < NP; k++) begin
            check_bit($sformatf("out_req_o[%0d]", k), out_req_o[k], 1'b0);
        end
        $display("All checks passed");
        $finish;
    end

endmodule
